// ==== filelist.f ====
design/posi_pkg.sv
design/posi_ram_sp.sv
design/posi_memory_wrapper.sv
design/posi_edge_writer.sv
design/posi_nbr_fetch.sv
design/posi_top.sv
tb/posi_properties.sv
tb/posi_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the edge memory testbench with Verilator, run it, then scan the log

cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module posi_tb -Mdir obj_dir -f filelist.f > "$build_log" 2>&1
if [ $? -ne 0 ]; then
  cat "$build_log"
  echo "build failed"
  exit 1
fi

./obj_dir/Vposi_tb > "$sim_log" 2>&1
sim_status=$?
cat "$sim_log"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "Regression failed" "$sim_log"; then
  exit 1
fi
exit 0

// ==== tb/posi_tb.sv ====
// self-checking testbench for posi_top with random block fills and requests against an edge model
`timescale 1ns/1ps

module posi_tb
  import posi_pkg::*;
();

  localparam ctu_idx_t CTU_A          = 6'd5;
  localparam ctu_idx_t CTU_B          = 6'd9;
  localparam int       ANSWER_TIMEOUT = 16;
  // mid-grey in all four samples
  localparam pix4_t    GREY4          = {4{8'd128}};

  logic       clk;
  logic       rst_n_i;
  logic       blk_vld_i;
  recon_blk_t blk_i;
  logic       req_vld_i;
  blk_pos_t   req_i;
  logic       nbr_vld_o;
  nbr_t       nbr_o;

  // edge model keyed like the rams
  pix4_t row_model [int];
  pix4_t col_model [int];
  pix4_t fra_model [int];

  // expected answers and the cycle of their request
  nbr_t exp_q [$];
  int   req_cyc_q [$];

  logic [31:0] rng_state = 32'd82;
  int          cyc = 0;
  int          answers_seen = 0;
  int          chk_cnt = 0;
  int          err_cnt = 0;
  int          chk_mark = 0;
  int          err_mark = 0;

  posi_top DUT (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .blk_vld_i (blk_vld_i),
    .blk_i     (blk_i),
    .req_vld_i (req_vld_i),
    .req_i     (req_i),
    .nbr_vld_o (nbr_vld_o),
    .nbr_o     (nbr_o)
  );

  // ------------------------------------------------------------
  // clock, cycle count, answer monitor
  // ------------------------------------------------------------

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  // answers sampled mid-cycle while the registered outputs are stable
  always @(negedge clk) begin
    if (nbr_vld_o === 1'b1) begin
      answers_seen++;
      if (exp_q.size() == 0) begin
        $display("answer at %0t without a pending request", $time);
        err_cnt++;
      end else begin
        check_answer(nbr_o, exp_q.pop_front(), cyc - req_cyc_q.pop_front());
      end
    end
  end

  // ------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------

  function automatic logic [31:0] xorshift_next();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  task automatic compare(input logic [63:0] got, input logic [63:0] exp, input string what);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("Mismatch at %0t: %s, got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  // one answer against its expectation and the two-cycle latency
  task automatic check_answer(input nbr_t got, input nbr_t exp, input int lat);
    compare(64'(got.top), 64'(exp.top), "top pixels");
    compare(64'(got.left), 64'(exp.left), "left pixels");
    compare(64'(got.top_avail), 64'(exp.top_avail), "top_avail");
    compare(64'(got.left_avail), 64'(exp.left_avail), "left_avail");
    compare(64'(lat), 64'd2, "answer latency");
  endtask

  task automatic idle_cycle();
    @(negedge clk);
    blk_vld_i = 1'b0;
    req_vld_i = 1'b0;
  endtask

  // random block written to the dut and the edge model
  task automatic write_block(input ctu_idx_t cx, input ctu_idx_t cy,
                             input blk_idx_t bx, input blk_idx_t by);
    recon_blk_t blk;
    pix4_t      col;
    blk.pos.ctu_x = cx;
    blk.pos.ctu_y = cy;
    blk.pos.blk_x = bx;
    blk.pos.blk_y = by;
    for (int i = 0; i < 4; i++) begin
      blk.rows[i] = xorshift_next();
      col[i]      = blk.rows[i][3];
    end
    row_model[int'(by) * 16 + int'(bx)] = blk.rows[3];
    col_model[int'(bx) * 16 + int'(by)] = col;
    // last block row also feeds the frame line
    if (by == 4'd15) begin
      fra_model[int'(cx) * 16 + int'(bx)] = blk.rows[3];
    end
    @(negedge clk);
    blk_i     = blk;
    blk_vld_i = 1'b1;
    req_vld_i = 1'b0;
  endtask

  task automatic fill_ctu(input ctu_idx_t cx);
    for (int y = 0; y < 16; y++) begin
      for (int x = 0; x < 16; x++) begin
        write_block(cx, 6'd0, blk_idx_t'(x), blk_idx_t'(y));
      end
    end
  endtask

  task automatic request(input ctu_idx_t cx, input ctu_idx_t cy,
                         input blk_idx_t bx, input blk_idx_t by);
    nbr_t exp;
    exp.top_avail  = (by != 4'd0) || (cy != 6'd0);
    exp.left_avail = (bx != 4'd0);
    // top from the frame line on the first block row, else the block above
    if (!exp.top_avail) begin
      exp.top = GREY4;
    end else if (by == 4'd0) begin
      exp.top = fra_model[int'(cx) * 16 + int'(bx)];
    end else begin
      exp.top = row_model[(int'(by) - 1) * 16 + int'(bx)];
    end
    if (exp.left_avail) begin
      exp.left = col_model[(int'(bx) - 1) * 16 + int'(by)];
    end else begin
      exp.left = GREY4;
    end
    @(negedge clk);
    blk_vld_i     = 1'b0;
    req_i.ctu_x   = cx;
    req_i.ctu_y   = cy;
    req_i.blk_x   = bx;
    req_i.blk_y   = by;
    req_vld_i     = 1'b1;
    exp_q.push_back(exp);
    req_cyc_q.push_back(cyc);
  endtask

  // wait for each pending answer with its own timeout
  task automatic drain_answers();
    int pending;
    int waited;
    idle_cycle();
    while (exp_q.size() > 0) begin
      pending = exp_q.size();
      waited  = 0;
      while (exp_q.size() == pending && waited < ANSWER_TIMEOUT) begin
        @(posedge clk);
        waited++;
      end
      if (exp_q.size() == pending) begin
        $display("no answer for a pending request within %0d cycles at %0t",
                 ANSWER_TIMEOUT, $time);
        err_cnt++;
        exp_q.delete();
        req_cyc_q.delete();
      end
    end
    // pipeline is two deep so any later answer is an extra one
    repeat (3) @(posedge clk);
  endtask

  task automatic finish_test(input string name);
    $display("test %s done, %0d checks, %0d errors", name, chk_cnt - chk_mark,
             err_cnt - err_mark);
    chk_mark = chk_cnt;
    err_mark = err_cnt;
  endtask

  // ------------------------------------------------------------
  // tests
  // ------------------------------------------------------------

  task automatic interior_neighbors();
    logic [31:0] r;
    fill_ctu(CTU_A);
    for (int n = 0; n < 40; n++) begin
      r = xorshift_next();
      request(CTU_A, 6'd0, blk_idx_t'(1 + r[7:0] % 15), blk_idx_t'(1 + r[15:8] % 15));
      if (r[31]) begin
        idle_cycle();
      end
    end
    drain_answers();
    finish_test("interior");
  endtask

  // second ctu overwrites row and column words while the frame line keeps both
  task automatic frame_line_neighbors();
    logic [31:0] r;
    fill_ctu(CTU_B);
    for (int n = 0; n < 32; n++) begin
      r = xorshift_next();
      request(r[0] ? CTU_B : CTU_A, 6'd1, r[4:1], 4'd0);
    end
    drain_answers();
    finish_test("frame_line");
  endtask

  task automatic missing_neighbors();
    logic [31:0] r;
    for (int n = 0; n < 30; n++) begin
      r = xorshift_next();
      case (int'(r % 3))
        0: request(CTU_B, 6'd0, 4'd0, blk_idx_t'(1 + r[7:4] % 15));
        1: request(CTU_B, 6'd0, r[11:8], 4'd0);
        default: request(CTU_B, 6'd0, 4'd0, 4'd0);
      endcase
    end
    drain_answers();
    finish_test("missing");
  endtask

  // rewrite then read right behind it
  task automatic rewrite_and_reread();
    logic [31:0] r;
    blk_idx_t    x;
    blk_idx_t    y;
    blk_idx_t    x2;
    for (int n = 0; n < 20; n++) begin
      r  = xorshift_next();
      x  = blk_idx_t'(r[3:0] % 15);
      y  = blk_idx_t'(r[7:4] % 15);
      x2 = r[11:8];
      write_block(CTU_B, 6'd0, x, y);
      write_block(CTU_B, 6'd0, x2, 4'd15);
      request(CTU_B, 6'd0, x, y + 4'd1);
      request(CTU_B, 6'd0, x + 4'd1, y);
      request(CTU_B, 6'd1, x2, 4'd0);
    end
    drain_answers();
    finish_test("rewrite");
  endtask

  task automatic back_to_back_burst();
    logic [31:0] r;
    int          mark;
    mark = answers_seen;
    for (int n = 0; n < 64; n++) begin
      r = xorshift_next();
      request(CTU_B, {5'd0, r[0]}, r[4:1], r[8:5]);
    end
    drain_answers();
    compare(64'(answers_seen - mark), 64'd64, "answer count");
    finish_test("burst");
  endtask

  // ------------------------------------------------------------
  // main
  // ------------------------------------------------------------

  initial begin
    rst_n_i   = 1'b0;
    blk_vld_i = 1'b0;
    blk_i     = '0;
    req_vld_i = 1'b0;
    req_i     = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n_i = 1'b1;
    interior_neighbors();
    frame_line_neighbors();
    missing_neighbors();
    rewrite_and_reread();
    back_to_back_burst();
    $display("total %0d checks, %0d errors", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== tb/posi_properties.sv ====
// concurrent checks on the posi_top strobes, attached to every posi_top instance by bind
`timescale 1ns/1ps

module posi_properties (
  input logic clk,
  input logic rst_n_i,
  input logic blk_vld_i,
  input logic req_vld_i,
  input logic nbr_vld_o
);

  // requests and block writes never share a cycle
  a_req_not_with_blk: assert property (
    @(posedge clk) disable iff (!rst_n_i) !(req_vld_i && blk_vld_i)
  ) else $error("request strobe in the same cycle as a block strobe");

  // every request is answered two cycles later
  a_req_answered: assert property (
    @(posedge clk) disable iff (!rst_n_i) req_vld_i |-> ##2 nbr_vld_o
  ) else $error("request not answered two cycles later");

  // and no answer comes without a request two cycles before
  a_answer_has_req: assert property (
    @(posedge clk) disable iff (!rst_n_i) nbr_vld_o |-> $past(req_vld_i, 2)
  ) else $error("answer without a request two cycles before");

  // answer strobe stays low while reset is held
  a_quiet_in_reset: assert property (
    @(posedge clk) !rst_n_i |=> !nbr_vld_o
  ) else $error("answer strobe high during reset");

endmodule

bind posi_top posi_properties u_properties (
  .clk       (clk),
  .rst_n_i   (rst_n_i),
  .blk_vld_i (blk_vld_i),
  .req_vld_i (req_vld_i),
  .nbr_vld_o (nbr_vld_o)
);

// ==== design/posi_top.sv ====
// post-intra edge memory top level; block writes in, neighbor requests answered two cycles later
`timescale 1ns/1ps

module posi_top
  import posi_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n_i,
  // reconstructed blocks
  input  logic       blk_vld_i,
  input  recon_blk_t blk_i,
  // neighbor requests, never in a block strobe cycle
  input  logic       req_vld_i,
  input  blk_pos_t   req_i,
  // neighbor answers
  output logic       nbr_vld_o,
  output nbr_t       nbr_o
);

  // ------------------------------------------------------------
  // internal wires
  // ------------------------------------------------------------

  // writer to wrapper
  ram_loc_wr_t row_wr;
  ram_loc_wr_t col_wr;
  ram_fra_wr_t fra_wr;

  // fetcher to wrapper and back
  logic     row_rd_ena;
  loc_adr_t row_rd_adr;
  logic     col_rd_ena;
  loc_adr_t col_rd_adr;
  logic     fra_rd_ena;
  fra_adr_t fra_rd_adr;
  pix4_t    row_rd_dat;
  pix4_t    col_rd_dat;
  pix4_t    fra_rd_dat;

  // ------------------------------------------------------------
  // instances
  // ------------------------------------------------------------

  posi_edge_writer u_edge_writer (
    .blk_vld_i (blk_vld_i),
    .blk_i     (blk_i),
    .row_wr_o  (row_wr),
    .col_wr_o  (col_wr),
    .fra_wr_o  (fra_wr)
  );

  posi_memory_wrapper u_memory_wrapper (
    .clk          (clk),
    .row_wr_i     (row_wr),
    .col_wr_i     (col_wr),
    .fra_wr_i     (fra_wr),
    .row_rd_ena_i (row_rd_ena),
    .row_rd_adr_i (row_rd_adr),
    .col_rd_ena_i (col_rd_ena),
    .col_rd_adr_i (col_rd_adr),
    .fra_rd_ena_i (fra_rd_ena),
    .fra_rd_adr_i (fra_rd_adr),
    .row_rd_dat_o (row_rd_dat),
    .col_rd_dat_o (col_rd_dat),
    .fra_rd_dat_o (fra_rd_dat)
  );

  posi_nbr_fetch u_nbr_fetch (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .req_vld_i    (req_vld_i),
    .req_i        (req_i),
    .row_rd_ena_o (row_rd_ena),
    .row_rd_adr_o (row_rd_adr),
    .col_rd_ena_o (col_rd_ena),
    .col_rd_adr_o (col_rd_adr),
    .fra_rd_ena_o (fra_rd_ena),
    .fra_rd_adr_o (fra_rd_adr),
    .row_rd_dat_i (row_rd_dat),
    .col_rd_dat_i (col_rd_dat),
    .fra_rd_dat_i (fra_rd_dat),
    .nbr_vld_o    (nbr_vld_o),
    .nbr_o        (nbr_o)
  );

endmodule

// ==== design/posi_nbr_fetch.sv ====
// turns a neighbor request into ram reads and returns top and left edges two cycles later
`timescale 1ns/1ps

module posi_nbr_fetch
  import posi_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n_i,
  // request, one cycle strobe
  input  logic     req_vld_i,
  input  blk_pos_t req_i,
  // ram reads
  output logic     row_rd_ena_o,
  output loc_adr_t row_rd_adr_o,
  output logic     col_rd_ena_o,
  output loc_adr_t col_rd_adr_o,
  output logic     fra_rd_ena_o,
  output fra_adr_t fra_rd_adr_o,
  input  pix4_t    row_rd_dat_i,
  input  pix4_t    col_rd_dat_i,
  input  pix4_t    fra_rd_dat_i,
  // answer
  output logic     nbr_vld_o,
  output nbr_t     nbr_o
);

  // side info that rides beside the ram read
  typedef struct packed {
    logic top_avail;
    logic top_fra;
    logic left_avail;
  } s1_info_t;

  // ------------------------------------------------------------
  // cycle 0, decode
  // ------------------------------------------------------------

  blk_idx_t up_y;
  blk_idx_t lf_x;
  s1_info_t s0_info;

  // block above and block to the left
  assign up_y = req_i.blk_y - 1'b1;
  assign lf_x = req_i.blk_x - 1'b1;

  // top row of the ctu reads the frame line
  assign s0_info.top_fra    = (req_i.blk_y == '0);
  // first ctu row has nothing above
  assign s0_info.top_avail  = !s0_info.top_fra || (req_i.ctu_y != '0);
  // no left neighbor across the ctu border
  assign s0_info.left_avail = (req_i.blk_x != '0);

  assign row_rd_ena_o = req_vld_i && !s0_info.top_fra;
  assign row_rd_adr_o = {up_y, req_i.blk_x};
  assign col_rd_ena_o = req_vld_i && s0_info.left_avail;
  assign col_rd_adr_o = {lf_x, req_i.blk_y};
  assign fra_rd_ena_o = req_vld_i && s0_info.top_fra && s0_info.top_avail;
  assign fra_rd_adr_o = {req_i.ctu_x, req_i.blk_x};

  // ------------------------------------------------------------
  // cycle 1, ram data back, select and substitute
  // ------------------------------------------------------------

  logic     s1_vld_q;
  s1_info_t s1_info_q;
  pix4_t    top_sel;
  pix4_t    left_sel;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      s1_vld_q <= 1'b0;
    end else begin
      s1_vld_q <= req_vld_i;
    end
  end

  always_ff @(posedge clk) begin
    s1_info_q <= s0_info;
  end

  // mid-grey where the neighbor is missing
  always_comb begin
    if (!s1_info_q.top_avail) begin
      top_sel = PIX4_DEFAULT;
    end else if (s1_info_q.top_fra) begin
      top_sel = fra_rd_dat_i;
    end else begin
      top_sel = row_rd_dat_i;
    end
    left_sel = s1_info_q.left_avail ? col_rd_dat_i : PIX4_DEFAULT;
  end

  // ------------------------------------------------------------
  // cycle 2, result
  // ------------------------------------------------------------

  logic s2_vld_q;
  nbr_t s2_nbr_q;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      s2_vld_q <= 1'b0;
    end else begin
      s2_vld_q <= s1_vld_q;
    end
  end

  always_ff @(posedge clk) begin
    s2_nbr_q.top        <= top_sel;
    s2_nbr_q.left       <= left_sel;
    s2_nbr_q.top_avail  <= s1_info_q.top_avail;
    s2_nbr_q.left_avail <= s1_info_q.left_avail;
  end

  assign nbr_vld_o = s2_vld_q;
  assign nbr_o     = s2_nbr_q;

endmodule

// ==== design/posi_edge_writer.sv ====
// splits each reconstructed 4x4 block into row, column and frame line writes
`timescale 1ns/1ps

module posi_edge_writer
  import posi_pkg::*;
(
  // one block per strobe
  input  logic        blk_vld_i,
  input  recon_blk_t  blk_i,
  // ram write ports, valid in the strobe cycle
  output ram_loc_wr_t row_wr_o,
  output ram_loc_wr_t col_wr_o,
  output ram_fra_wr_t fra_wr_o
);

  // ------------------------------------------------------------
  // edge extraction
  // ------------------------------------------------------------

  pix4_t bot_row;
  pix4_t rgt_col;
  logic  last_row;

  // bottom row goes out as is
  assign bot_row = blk_i.rows[BLK_EDGE];

  // right column, top sample lands in sample 0
  always_comb begin
    rgt_col = '0;
    for (int i = 0; i < 4; i++) begin
      rgt_col[i] = blk_i.rows[i][BLK_EDGE];
    end
  end

  // bottom block row of the ctu
  assign last_row = (blk_i.pos.blk_y == BLK_LAST);

  // ------------------------------------------------------------
  // write ports
  // ------------------------------------------------------------

  // row ram
  always_comb begin
    row_wr_o.ena = blk_vld_i;
    row_wr_o.adr = {blk_i.pos.blk_y, blk_i.pos.blk_x};
    row_wr_o.dat = bot_row;
  end

  // column ram, x major
  always_comb begin
    col_wr_o.ena = blk_vld_i;
    col_wr_o.adr = {blk_i.pos.blk_x, blk_i.pos.blk_y};
    col_wr_o.dat = rgt_col;
  end

  // frame line ram
  // only the last block row of a ctu, kept for the ctu row below
  always_comb begin
    fra_wr_o.ena = blk_vld_i && last_row;
    fra_wr_o.adr = {blk_i.pos.ctu_x, blk_i.pos.blk_x};
    fra_wr_o.dat = bot_row;
  end

endmodule

// ==== design/posi_memory_wrapper.sv ====
// row, column and frame edge rams behind one wrapper; writes take the address port over reads
`timescale 1ns/1ps

module posi_memory_wrapper
  import posi_pkg::*;
(
  input  logic        clk,
  // write side, from the edge writer
  input  ram_loc_wr_t row_wr_i,
  input  ram_loc_wr_t col_wr_i,
  input  ram_fra_wr_t fra_wr_i,
  // read side, from the neighbor fetcher
  input  logic        row_rd_ena_i,
  input  loc_adr_t    row_rd_adr_i,
  input  logic        col_rd_ena_i,
  input  loc_adr_t    col_rd_adr_i,
  input  logic        fra_rd_ena_i,
  input  fra_adr_t    fra_rd_adr_i,
  // read data, one cycle after enable
  output pix4_t       row_rd_dat_o,
  output pix4_t       col_rd_dat_o,
  output pix4_t       fra_rd_dat_o
);

  // ------------------------------------------------------------
  // address select
  // ------------------------------------------------------------

  loc_adr_t row_adr;
  loc_adr_t col_adr;
  fra_adr_t fra_adr;

  // write enable owns the port
  assign row_adr = row_wr_i.ena ? row_wr_i.adr : row_rd_adr_i;
  assign col_adr = col_wr_i.ena ? col_wr_i.adr : col_rd_adr_i;
  assign fra_adr = fra_wr_i.ena ? fra_wr_i.adr : fra_rd_adr_i;

  // ------------------------------------------------------------
  // rams
  // ------------------------------------------------------------

  // bottom rows, {blk_y, blk_x}
  posi_ram_sp #(
    .ADR_WIDTH (LOC_ADR_WIDTH)
  ) u_ram_row (
    .clk      (clk),
    .adr_i    (row_adr),
    .wr_ena_i (row_wr_i.ena),
    .wr_dat_i (row_wr_i.dat),
    .rd_ena_i (row_rd_ena_i),
    .rd_dat_o (row_rd_dat_o)
  );

  // right columns, {blk_x, blk_y}
  posi_ram_sp #(
    .ADR_WIDTH (LOC_ADR_WIDTH)
  ) u_ram_col (
    .clk      (clk),
    .adr_i    (col_adr),
    .wr_ena_i (col_wr_i.ena),
    .wr_dat_i (col_wr_i.dat),
    .rd_ena_i (col_rd_ena_i),
    .rd_dat_o (col_rd_dat_o)
  );

  // frame line, {ctu_x, blk_x}
  posi_ram_sp #(
    .ADR_WIDTH (FRA_ADR_WIDTH)
  ) u_ram_fra (
    .clk      (clk),
    .adr_i    (fra_adr),
    .wr_ena_i (fra_wr_i.ena),
    .wr_dat_i (fra_wr_i.dat),
    .rd_ena_i (fra_rd_ena_i),
    .rd_dat_o (fra_rd_dat_o)
  );

endmodule

// ==== design/posi_ram_sp.sv ====
// single-port 32-bit ram model with registered read, instantiated per edge memory
`timescale 1ns/1ps

module posi_ram_sp
  import posi_pkg::*;
#(
  parameter int ADR_WIDTH = LOC_ADR_WIDTH
) (
  input  logic                 clk,
  // shared address, write wins
  input  logic [ADR_WIDTH-1:0] adr_i,
  input  logic                 wr_ena_i,
  input  pix4_t                wr_dat_i,
  input  logic                 rd_ena_i,
  output pix4_t                rd_dat_o
);

  // storage, one pix4 word per address
  pix4_t mem_q [0:(1 << ADR_WIDTH)-1];
  pix4_t rd_dat_q;

  // write port
  always_ff @(posedge clk) begin
    if (wr_ena_i) begin
      mem_q[adr_i] <= wr_dat_i;
    end
  end

  // read port, output holds between reads
  always_ff @(posedge clk) begin
    if (rd_ena_i) begin
      rd_dat_q <= mem_q[adr_i];
    end
  end

  assign rd_dat_o = rd_dat_q;

endmodule

// ==== design/posi_pkg.sv ====
// shared widths, vector types, structs and address mapping constants for the post-intra edge memory
package posi_pkg;

  // ------------------------------------------------------------
  // widths
  // ------------------------------------------------------------

  // bits per sample
  localparam int PIXEL_WIDTH   = 8;
  // ctu column index, up to 64 ctus across
  localparam int PIC_X_WIDTH   = 6;
  // 4x4 block index inside a 64x64 ctu
  localparam int BLK_IDX_WIDTH = 4;
  // row and column rams, 256 words
  localparam int LOC_ADR_WIDTH = 8;
  // frame line ram, 1024 words
  localparam int FRA_ADR_WIDTH = 10;

  // ------------------------------------------------------------
  // vector types
  // ------------------------------------------------------------

  typedef logic [PIXEL_WIDTH-1:0]   pixel_t;
  // sample 0 sits in the low bits
  typedef pixel_t [3:0]             pix4_t;
  typedef logic [PIC_X_WIDTH-1:0]   ctu_idx_t;
  typedef logic [BLK_IDX_WIDTH-1:0] blk_idx_t;
  typedef logic [LOC_ADR_WIDTH-1:0] loc_adr_t;
  typedef logic [FRA_ADR_WIDTH-1:0] fra_adr_t;

  // ------------------------------------------------------------
  // mapping constants
  // ------------------------------------------------------------

  // mid-grey, half the sample range
  localparam pixel_t   PIX_DEFAULT  = pixel_t'(1 << (PIXEL_WIDTH - 1));
  localparam pix4_t    PIX4_DEFAULT = {4{PIX_DEFAULT}};
  // last block row of a ctu, feeds the frame line
  localparam blk_idx_t BLK_LAST     = '1;
  // bottom row / right column inside a 4x4 block
  localparam int       BLK_EDGE     = 3;

  // ------------------------------------------------------------
  // structs
  // ------------------------------------------------------------

  typedef struct packed {
    ctu_idx_t ctu_x;
    ctu_idx_t ctu_y;
    blk_idx_t blk_x;
    blk_idx_t blk_y;
  } blk_pos_t;

  // rows[0] is the top row
  typedef struct packed {
    blk_pos_t    pos;
    pix4_t [3:0] rows;
  } recon_blk_t;

  // write port, row and column ram flavour
  typedef struct packed {
    logic     ena;
    loc_adr_t adr;
    pix4_t    dat;
  } ram_loc_wr_t;

  // write port, frame ram flavour
  typedef struct packed {
    logic     ena;
    fra_adr_t adr;
    pix4_t    dat;
  } ram_fra_wr_t;

  typedef struct packed {
    pix4_t top;
    pix4_t left;
    logic  top_avail;
    logic  left_avail;
  } nbr_t;

endpackage
